/* Bender.yml */
package:
  name: mips_core

sources:
  - logic/mips_isa_pkg.sv
  - logic/pipe_pkg.sv
  - logic/fetch_stage.sv
  - logic/decode_stage.sv
  - logic/execute_stage.sv
  - logic/memory_stage.sv
  - logic/mips_core.sv
  - target: test
    files:
      - dv/mips_core_props.sv
      - dv/mips_core_tb.sv

/* all.f */
logic/mips_isa_pkg.sv
logic/pipe_pkg.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/mips_core.sv
dv/mips_core_props.sv
dv/mips_core_tb.sv

/* dv/mips_core_props.sv */
`timescale 1ns/1ns
module mips_core_props (
    input logic                                clk,
    input logic                                reset,
    input logic                                wb_valid,
    input logic [mips_isa_pkg::reg_addr_w-1:0] wb_reg,
    input logic                                store_valid
);

    // r0 writes are dropped in the memory stage
    wb_reg_nonzero: assert property (
        @(posedge clk) disable iff (reset) wb_valid |-> wb_reg != '0)
        else $error("writeback strobe raised for register zero");

    // pipeline comes out of reset empty
    quiet_after_reset: assert property (
        @(posedge clk) $fell(reset) |-> !wb_valid && !store_valid)
        else $error("wb or store strobe high in the first cycle after reset");

    // store slot sits in mem_wb while its strobe is up
    store_no_wb: assert property (
        @(posedge clk) disable iff (reset) store_valid |-> !wb_valid)
        else $error("store slot also reported a writeback");

endmodule

/* dv/mips_core_tb.sv */
`timescale 1ns/1ns
module mips_core_tb;

    localparam int unsigned clk_period  = 8;
    localparam logic [31:0] lfsr_seed   = 32'd66804;
    localparam logic [31:0] lfsr_taps   = 32'h8020_0003;
    localparam int unsigned test_count  = 5;
    // reset, full imem load, run up to two passes of imem, drain
    localparam int unsigned test_cycles = 3 + 3 * mips_isa_pkg::imem_depth + 16;
    localparam logic [4:0]  marker_reg  = 5'd31;

    logic                                clk;
    logic                                reset;
    logic                                run;
    logic                                load_en;
    logic [mips_isa_pkg::imem_aw-1:0]    load_addr;
    logic [mips_isa_pkg::xlen-1:0]       load_data;
    logic                                wb_valid;
    logic [mips_isa_pkg::reg_addr_w-1:0] wb_reg;
    logic [mips_isa_pkg::xlen-1:0]       wb_data;
    logic                                store_valid;
    logic [mips_isa_pkg::xlen-1:0]       store_addr;
    logic [mips_isa_pkg::xlen-1:0]       store_data;

    logic [31:0] lfsr_state = lfsr_seed;
    logic [31:0] prog [$];
    logic [63:0] wb_q [$];          // {reg, data} seen on the wb port
    logic [63:0] st_q [$];          // {addr, data} seen on the store port
    logic [63:0] exp_wb [$];
    logic [63:0] exp_st [$];
    logic [31:0] model_rf [32] = '{default: '0};   // persists across resets, like the DUT
    logic [31:0] model_mem [mips_isa_pkg::dmem_depth];
    bit          model_written [mips_isa_pkg::dmem_depth];
    bit          marker_seen;

    mips_core dut (.*);

    bind mips_core mips_core_props u_props (.*);

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // outputs move on the rising edge
    always @(negedge clk) begin
        if (wb_valid) begin
            wb_q.push_back(64'({wb_reg, wb_data}));
            if (wb_reg == marker_reg) begin
                marker_seen = 1'b1;
            end
        end
        if (store_valid) begin
            st_q.push_back({store_addr, store_data});
        end
    end

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic report_mismatch(input string test, input string what, input int idx,
                                   input logic [63:0] exp, input logic [63:0] act);
        fail_now($sformatf("Error: %s %s #%0d expected %h actual %h",
                           test, what, idx, exp, act));
    endtask

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] rand_bits(input int unsigned n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ lfsr_taps) : (lfsr_state >> 1);
        end
        return v;
    endfunction

    function automatic logic [31:0] enc_r(input mips_isa_pkg::funct_e fn, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [4:0] rd,
                                          input logic [4:0] sh);
        return {mips_isa_pkg::op_r_type, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] enc_i(input mips_isa_pkg::opcode_e op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic put_nops(input int n);
        repeat (n) prog.push_back('0);   // sll r0, r0, 0
    endtask

    function automatic void write_reg(input logic [4:0] r, input logic [31:0] v);
        if (r != '0) begin
            model_rf[r] = v;
            exp_wb.push_back(64'({r, v}));
        end
    endfunction

    // in-order model without delay slots, flushed slots simply never execute
    task automatic run_model();
        logic [31:0] pc;
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sext;
        logic [31:0] addr;
        int unsigned idx;
        pc = '0;
        exp_wb.delete();
        exp_st.delete();
        model_written = '{default: 1'b0};   // reset clears the written flags
        while (pc / 4 < prog.size()) begin
            w    = prog[pc / 4];
            a    = model_rf[w[25:21]];
            b    = model_rf[w[20:16]];
            sext = {{16{w[15]}}, w[15:0]};
            addr = a + sext;
            idx  = (addr >> 2) % mips_isa_pkg::dmem_depth;
            pc   = pc + 4;
            case (w[31:26])
                mips_isa_pkg::op_r_type: begin
                    case (w[5:0])
                        mips_isa_pkg::fn_add: write_reg(w[15:11], a + b);
                        mips_isa_pkg::fn_sub: write_reg(w[15:11], a - b);
                        mips_isa_pkg::fn_and: write_reg(w[15:11], a & b);
                        mips_isa_pkg::fn_or:  write_reg(w[15:11], a | b);
                        mips_isa_pkg::fn_slt: write_reg(w[15:11], {31'b0, $signed(a) < $signed(b)});
                        mips_isa_pkg::fn_sll: write_reg(w[15:11], b << w[10:6]);
                        default: ;
                    endcase
                end
                mips_isa_pkg::op_addi: write_reg(w[20:16], addr);
                mips_isa_pkg::op_lw:   write_reg(w[20:16], model_written[idx] ? model_mem[idx] : '0);
                mips_isa_pkg::op_sw: begin
                    model_mem[idx]     = b;
                    model_written[idx] = 1'b1;
                    exp_st.push_back({addr, b});
                end
                mips_isa_pkg::op_beq: begin
                    if (a == b) begin
                        pc = pc + (sext << 2);
                    end
                end
                default: ;
            endcase
        end
    endtask

    task automatic reset_dut();
        @(posedge clk);
        reset <= 1'b1;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        wb_q.delete();
        st_q.delete();
        marker_seen = 1'b0;
    endtask

    task automatic load_program();
        for (int i = 0; i < mips_isa_pkg::imem_depth; i++) begin
            @(posedge clk);
            load_en   <= 1'b1;
            load_addr <= mips_isa_pkg::imem_aw'(i);
            // past the end, addi r0 words tagged with their own address
            load_data <= (i < prog.size()) ? prog[i]
                                           : enc_i(mips_isa_pkg::op_addi, 0, 0, 16'(i));
        end
        @(posedge clk);
        load_en <= 1'b0;
    endtask

    task automatic compare_events(input string name, input string what,
                                  input logic [63:0] exp [$], input logic [63:0] act [$]);
        foreach (exp[i]) begin
            assert (i < act.size())
                else fail_now($sformatf("%s: %s #%0d never arrived", name, what, i));
            assert (act[i] === exp[i])
                else report_mismatch(name, what, i, exp[i], act[i]);
        end
        assert (act.size() == exp.size())
            else fail_now($sformatf("%s: %0d more %s events than the program makes",
                                    name, act.size() - exp.size(), what));
    endtask

    // appends the end marker, runs the program and checks both event streams
    task automatic run_test(input string name);
        int unsigned cycles;
        prog.push_back(enc_i(mips_isa_pkg::op_addi, 0, marker_reg, 16'h0a5a));
        reset_dut();
        load_program();
        assert (wb_q.size() == 0 && st_q.size() == 0)
            else fail_now($sformatf("%s: writeback or store reported before run", name));
        run_model();
        @(posedge clk);
        run    <= 1'b1;
        cycles = 0;
        while (!marker_seen && cycles < 2 * mips_isa_pkg::imem_depth) begin
            @(posedge clk);
            cycles++;
        end
        run <= 1'b0;
        assert (marker_seen)
            else fail_now($sformatf("%s: end of program writeback never arrived", name));
        compare_events(name, "writeback", exp_wb, wb_q);
        compare_events(name, "store", exp_st, st_q);
        prog.delete();
    endtask

    task automatic test_reset_idle();
        prog.push_back(enc_i(mips_isa_pkg::op_addi, 0, 0, 16'(rand_bits(16))));
        prog.push_back(enc_r(mips_isa_pkg::fn_or, 0, 0, 0, 0));
        prog.push_back(enc_r(mips_isa_pkg::fn_sll, 0, 0, 0, 5'(rand_bits(5))));
        run_test("reset_idle");
    endtask

    task automatic test_alu_ops();
        prog.push_back(enc_i(mips_isa_pkg::op_addi, 0, 1, 16'(rand_bits(16))));
        prog.push_back(enc_i(mips_isa_pkg::op_addi, 0, 2, 16'(rand_bits(16))));
        prog.push_back(enc_i(mips_isa_pkg::op_addi, 0, 3, 16'h8000 | 16'(rand_bits(15))));
        put_nops(2);
        prog.push_back(enc_r(mips_isa_pkg::fn_add, 1, 2, 4, 0));
        prog.push_back(enc_r(mips_isa_pkg::fn_sub, 1, 2, 5, 0));
        prog.push_back(enc_r(mips_isa_pkg::fn_and, 1, 2, 6, 0));
        prog.push_back(enc_r(mips_isa_pkg::fn_or, 1, 3, 7, 0));
        prog.push_back(enc_r(mips_isa_pkg::fn_slt, 1, 2, 8, 0));
        prog.push_back(enc_r(mips_isa_pkg::fn_slt, 3, 1, 9, 0));   // negative left operand
        prog.push_back(enc_r(mips_isa_pkg::fn_slt, 1, 3, 10, 0));
        run_test("alu_ops");
    endtask

    task automatic test_shift_imm();
        prog.push_back(enc_i(mips_isa_pkg::op_addi, 0, 12, 16'(rand_bits(16))));
        prog.push_back(enc_i(mips_isa_pkg::op_addi, 0, 13, 16'h8000 | 16'(rand_bits(15))));
        put_nops(2);
        prog.push_back(enc_r(mips_isa_pkg::fn_sll, 0, 12, 14, 5'(rand_bits(5))));
        prog.push_back(enc_r(mips_isa_pkg::fn_sll, 0, 12, 15, 5'(rand_bits(5))));
        prog.push_back(enc_r(mips_isa_pkg::fn_sll, 0, 13, 16, 5'd31));
        prog.push_back(enc_r(mips_isa_pkg::fn_sll, 0, 13, 17, 5'd0));
        prog.push_back(enc_i(mips_isa_pkg::op_addi, 12, 18, 16'h8000 | 16'(rand_bits(15))));
        prog.push_back(enc_i(mips_isa_pkg::op_addi, 13, 19, 16'hffff));
        run_test("shift_imm");
    endtask

    task automatic test_load_store();
        prog.push_back(enc_i(mips_isa_pkg::op_addi, 0, 20, 16'(rand_bits(16))));
        prog.push_back(enc_i(mips_isa_pkg::op_addi, 0, 21, 16'(rand_bits(5) << 2)));
        put_nops(2);
        prog.push_back(enc_i(mips_isa_pkg::op_sw, 21, 20, 16'd4));
        prog.push_back(enc_i(mips_isa_pkg::op_sw, 21, 21, 16'd8));
        put_nops(2);
        prog.push_back(enc_i(mips_isa_pkg::op_lw, 21, 22, 16'd4));
        prog.push_back(enc_i(mips_isa_pkg::op_lw, 21, 23, 16'd0));   // never stored
        prog.push_back(enc_i(mips_isa_pkg::op_lw, 21, 24, 16'd8));
        run_test("load_store");
    endtask

    task automatic test_branch();
        logic [15:0] v;
        v = 16'(rand_bits(16));
        prog.push_back(enc_i(mips_isa_pkg::op_addi, 0, 24, v));
        prog.push_back(enc_i(mips_isa_pkg::op_addi, 0, 25, v));
        prog.push_back(enc_i(mips_isa_pkg::op_addi, 0, 26, v ^ 16'h0001));
        put_nops(2);
        prog.push_back(enc_i(mips_isa_pkg::op_beq, 24, 26, 16'd2));   // not taken
        prog.push_back(enc_i(mips_isa_pkg::op_addi, 0, 27, 16'd1));
        prog.push_back(enc_i(mips_isa_pkg::op_addi, 0, 28, 16'd2));
        prog.push_back(enc_i(mips_isa_pkg::op_beq, 24, 25, 16'd3));   // taken
        prog.push_back(enc_i(mips_isa_pkg::op_addi, 0, 27, 16'd3));   // flushed
        prog.push_back(enc_i(mips_isa_pkg::op_addi, 0, 28, 16'd4));   // flushed
        prog.push_back(enc_i(mips_isa_pkg::op_addi, 0, 29, 16'd5));
        prog.push_back(enc_i(mips_isa_pkg::op_addi, 0, 30, 16'd6));   // branch target
        run_test("branch");
    endtask

    initial begin
        reset     = 1'b1;
        run       = 1'b0;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        test_reset_idle();
        test_alu_ops();
        test_shift_imm();
        test_load_store();
        test_branch();
        $display("ALL TESTS PASSED");
        $finish;
    end

    initial begin
        #(test_count * test_cycles * clk_period);
        fail_now("watchdog expired before all tests finished");
    end

endmodule

/* logic/decode_stage.sv */
`timescale 1ns/1ns
module decode_stage (
    input  logic                clk,
    input  logic                reset,
    input  pipe_pkg::if_id_t    if_id,
    input  logic                flush,
    input  pipe_pkg::mem_wb_t   wb,
    output pipe_pkg::id_ex_t    id_ex
);

    logic [mips_isa_pkg::xlen-1:0]       rf [mips_isa_pkg::num_regs];
    logic [mips_isa_pkg::reg_addr_w-1:0] rs;
    logic [mips_isa_pkg::reg_addr_w-1:0] rt;
    logic [mips_isa_pkg::reg_addr_w-1:0] rd;
    logic [mips_isa_pkg::shamt_w-1:0]    shamt;
    logic [mips_isa_pkg::imm_w-1:0]      imm_raw;
    logic [mips_isa_pkg::xlen-1:0]       imm_ext;
    logic [mips_isa_pkg::xlen-1:0]       rs_data;
    logic [mips_isa_pkg::xlen-1:0]       rt_data;
    logic                                wb_en;
    mips_isa_pkg::opcode_e               opcode;
    mips_isa_pkg::funct_e                funct;
    pipe_pkg::ctrl_t                     ctrl;

    // instruction fields
    assign opcode  = mips_isa_pkg::opcode_e'(if_id.instr[mips_isa_pkg::opcode_lsb +:
                                                         mips_isa_pkg::opcode_w]);
    assign funct   = mips_isa_pkg::funct_e'(if_id.instr[mips_isa_pkg::funct_w-1:0]);
    assign rs      = if_id.instr[mips_isa_pkg::rs_lsb +: mips_isa_pkg::reg_addr_w];
    assign rt      = if_id.instr[mips_isa_pkg::rt_lsb +: mips_isa_pkg::reg_addr_w];
    assign rd      = if_id.instr[mips_isa_pkg::rd_lsb +: mips_isa_pkg::reg_addr_w];
    assign shamt   = if_id.instr[mips_isa_pkg::shamt_lsb +: mips_isa_pkg::shamt_w];
    assign imm_raw = if_id.instr[mips_isa_pkg::imm_w-1:0];
    assign imm_ext = {{(mips_isa_pkg::xlen - mips_isa_pkg::imm_w){imm_raw[mips_isa_pkg::imm_w-1]}},
                      imm_raw};

    // writeback port, r0 never stored
    assign wb_en = wb.valid & wb.reg_write & (wb.dest != '0);

    always_ff @(posedge clk) begin
        if (wb_en) begin
            rf[wb.dest] <= wb.result;
        end
    end

    // read ports with write-through from the same cycle's writeback
    always_comb begin
        if (rs == '0)                      rs_data = '0;
        else if (wb_en && wb.dest == rs)   rs_data = wb.result;
        else                               rs_data = rf[rs];

        if (rt == '0)                      rt_data = '0;
        else if (wb_en && wb.dest == rt)   rt_data = wb.result;
        else                               rt_data = rf[rt];
    end

    // control decoder
    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = pipe_pkg::alu_pass;
        case (opcode)
            mips_isa_pkg::op_r_type: begin
                ctrl.reg_dst   = 1'b1;
                ctrl.reg_write = 1'b1;
                case (funct)
                    mips_isa_pkg::fn_add: ctrl.alu_op = pipe_pkg::alu_add;
                    mips_isa_pkg::fn_sub: ctrl.alu_op = pipe_pkg::alu_sub;
                    mips_isa_pkg::fn_and: ctrl.alu_op = pipe_pkg::alu_and;
                    mips_isa_pkg::fn_or:  ctrl.alu_op = pipe_pkg::alu_or;
                    mips_isa_pkg::fn_slt: ctrl.alu_op = pipe_pkg::alu_slt;
                    mips_isa_pkg::fn_sll: ctrl.alu_op = pipe_pkg::alu_sll;
                    default:              ctrl.reg_write = 1'b0; // unsupported funct
                endcase
            end
            mips_isa_pkg::op_addi: begin
                ctrl.alu_src   = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = pipe_pkg::alu_add;
            end
            mips_isa_pkg::op_lw: begin
                ctrl.alu_src    = 1'b1;
                ctrl.reg_write  = 1'b1;
                ctrl.mem_read   = 1'b1;
                ctrl.mem_to_reg = 1'b1;
                ctrl.alu_op     = pipe_pkg::alu_add;
            end
            mips_isa_pkg::op_sw: begin
                ctrl.alu_src   = 1'b1;
                ctrl.mem_write = 1'b1;
                ctrl.alu_op    = pipe_pkg::alu_add;
            end
            mips_isa_pkg::op_beq: begin
                ctrl.branch = 1'b1;
                ctrl.alu_op = pipe_pkg::alu_sub;
            end
            default: ;                      // unknown opcode acts as a bubble
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            id_ex <= '0;
        end else begin
            id_ex.valid   <= if_id.valid & ~flush;
            id_ex.pc      <= if_id.pc;
            id_ex.rs_data <= rs_data;
            id_ex.rt_data <= rt_data;
            id_ex.imm     <= imm_ext;
            id_ex.rt      <= rt;
            id_ex.rd      <= rd;
            id_ex.shamt   <= shamt;
            id_ex.ctrl    <= ctrl;
        end
    end

endmodule

/* logic/execute_stage.sv */
`timescale 1ns/1ns
module execute_stage (
    input  logic                            clk,
    input  logic                            reset,
    input  pipe_pkg::id_ex_t                id_ex,
    output logic                            redirect,
    output logic [mips_isa_pkg::xlen-1:0]   redirect_pc,
    output pipe_pkg::ex_mem_t               ex_mem
);

    logic [mips_isa_pkg::xlen-1:0]       op_a;
    logic [mips_isa_pkg::xlen-1:0]       op_b;
    logic [mips_isa_pkg::xlen-1:0]       alu_result;
    logic [mips_isa_pkg::reg_addr_w-1:0] dest;
    logic                                regs_equal;

    assign op_a = id_ex.rs_data;
    assign op_b = id_ex.ctrl.alu_src ? id_ex.imm : id_ex.rt_data;

    always_comb begin
        case (id_ex.ctrl.alu_op)
            pipe_pkg::alu_add: alu_result = op_a + op_b;
            pipe_pkg::alu_sub: alu_result = op_a - op_b;
            pipe_pkg::alu_and: alu_result = op_a & op_b;
            pipe_pkg::alu_or:  alu_result = op_a | op_b;
            pipe_pkg::alu_slt: begin
                // signed compare
                alu_result = ($signed(op_a) < $signed(op_b)) ? mips_isa_pkg::xlen'(1) : '0;
            end
            pipe_pkg::alu_sll: alu_result = id_ex.rt_data << id_ex.shamt;
            default:           alu_result = op_b;   // pass
        endcase
    end

    assign dest = id_ex.ctrl.reg_dst ? id_ex.rd : id_ex.rt;

    // beq resolves here, target relative to pc + 4
    assign regs_equal  = (id_ex.rs_data == id_ex.rt_data);
    assign redirect    = id_ex.valid & id_ex.ctrl.branch & regs_equal;
    assign redirect_pc = id_ex.pc + mips_isa_pkg::xlen'(4) + (id_ex.imm << 2);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ex_mem <= '0;
        end else begin
            ex_mem.valid      <= id_ex.valid;
            ex_mem.alu_result <= alu_result;
            ex_mem.store_data <= id_ex.rt_data;   // sw source register
            ex_mem.dest       <= dest;
            ex_mem.ctrl       <= id_ex.ctrl;
        end
    end

endmodule

/* logic/fetch_stage.sv */
`timescale 1ns/1ns
module fetch_stage (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                run,
    input  logic                                load_en,
    input  logic [mips_isa_pkg::imem_aw-1:0]    load_addr,
    input  logic [mips_isa_pkg::xlen-1:0]       load_data,
    input  logic                                redirect,
    input  logic [mips_isa_pkg::xlen-1:0]       redirect_pc,
    output pipe_pkg::if_id_t                    if_id
);

    logic [mips_isa_pkg::xlen-1:0] imem [mips_isa_pkg::imem_depth];
    logic [mips_isa_pkg::xlen-1:0] pc;
    logic [mips_isa_pkg::xlen-1:0] pc_next;
    logic [mips_isa_pkg::xlen-1:0] fetch_word;

    // program load port, one word per strobe
    always_ff @(posedge clk) begin
        if (load_en) begin
            imem[load_addr] <= load_data;
        end
    end

    // byte pc, word indexed memory
    assign fetch_word = imem[pc[mips_isa_pkg::imem_aw+1:2]];

    always_comb begin
        pc_next = pc;
        if (redirect) begin
            pc_next = redirect_pc;          // taken branch wins
        end else if (run) begin
            pc_next = pc + mips_isa_pkg::xlen'(4);
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc    <= '0;
            if_id <= '0;
        end else begin
            pc          <= pc_next;
            // slot fetched while a branch resolves is a wrong-path slot
            if_id.valid <= run & ~redirect;
            if_id.pc    <= pc;
            if_id.instr <= fetch_word;
        end
    end

endmodule

/* logic/memory_stage.sv */
`timescale 1ns/1ns
module memory_stage (
    input  logic                            clk,
    input  logic                            reset,
    input  pipe_pkg::ex_mem_t               ex_mem,
    output pipe_pkg::mem_wb_t               mem_wb,
    output logic                            store_valid,
    output logic [mips_isa_pkg::xlen-1:0]   store_addr,
    output logic [mips_isa_pkg::xlen-1:0]   store_data
);

    logic [mips_isa_pkg::xlen-1:0]       dmem [mips_isa_pkg::dmem_depth];
    logic [mips_isa_pkg::dmem_depth-1:0] written;   // per-word, unwritten reads zero
    logic [mips_isa_pkg::dmem_aw-1:0]    word_idx;
    logic [mips_isa_pkg::xlen-1:0]       load_data;
    logic                                do_store;

    assign word_idx = ex_mem.alu_result[mips_isa_pkg::dmem_aw+1:2];
    assign do_store = ex_mem.valid & ex_mem.ctrl.mem_write;

    assign load_data = (ex_mem.ctrl.mem_read && written[word_idx]) ? dmem[word_idx] : '0;

    always_ff @(posedge clk) begin
        if (do_store) begin
            dmem[word_idx] <= ex_mem.store_data;
        end
        store_addr <= ex_mem.alu_result;
        store_data <= ex_mem.store_data;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            written     <= '0;
            store_valid <= 1'b0;
            mem_wb      <= '0;
        end else begin
            if (do_store) begin
                written[word_idx] <= 1'b1;
            end
            store_valid      <= do_store;
            mem_wb.valid     <= ex_mem.valid;
            mem_wb.result    <= ex_mem.ctrl.mem_to_reg ? load_data : ex_mem.alu_result;
            mem_wb.dest      <= ex_mem.dest;
            // r0 writes never leave this stage
            mem_wb.reg_write <= ex_mem.valid & ex_mem.ctrl.reg_write & (ex_mem.dest != '0);
        end
    end

endmodule

/* logic/mips_core.sv */
`timescale 1ns/1ns
module mips_core (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                run,
    input  logic                                load_en,
    input  logic [mips_isa_pkg::imem_aw-1:0]    load_addr,
    input  logic [mips_isa_pkg::xlen-1:0]       load_data,
    output logic                                wb_valid,
    output logic [mips_isa_pkg::reg_addr_w-1:0] wb_reg,
    output logic [mips_isa_pkg::xlen-1:0]       wb_data,
    output logic                                store_valid,
    output logic [mips_isa_pkg::xlen-1:0]       store_addr,
    output logic [mips_isa_pkg::xlen-1:0]       store_data
);

    pipe_pkg::if_id_t              if_id;
    pipe_pkg::id_ex_t              id_ex;
    pipe_pkg::ex_mem_t             ex_mem;
    pipe_pkg::mem_wb_t             mem_wb;
    logic                          redirect;
    logic [mips_isa_pkg::xlen-1:0] redirect_pc;

    fetch_stage u_fetch (
        .clk, .reset, .run, .load_en, .load_addr, .load_data,
        .redirect, .redirect_pc, .if_id
    );

    decode_stage u_decode (
        .clk, .reset, .if_id,
        .flush (redirect),      // second wrong-path slot
        .wb    (mem_wb),        // writeback loop
        .id_ex
    );

    execute_stage u_execute (
        .clk, .reset, .id_ex, .redirect, .redirect_pc, .ex_mem
    );

    memory_stage u_memory (
        .clk, .reset, .ex_mem, .mem_wb, .store_valid, .store_addr, .store_data
    );

    // reg_write already qualified by valid and a non-zero destination
    assign wb_valid = mem_wb.reg_write;
    assign wb_reg   = mem_wb.dest;
    assign wb_data  = mem_wb.result;

endmodule

/* logic/mips_isa_pkg.sv */
package mips_isa_pkg;

    // datapath and register file sizes
    localparam int unsigned xlen       = 32;
    localparam int unsigned reg_addr_w = 5;
    localparam int unsigned num_regs   = 2 ** reg_addr_w;

    // instruction field widths
    localparam int unsigned opcode_w = 6;
    localparam int unsigned funct_w  = 6;
    localparam int unsigned shamt_w  = 5;
    localparam int unsigned imm_w    = 16;

    // field positions inside the instruction word
    localparam int unsigned opcode_lsb = 26;
    localparam int unsigned rs_lsb     = 21;
    localparam int unsigned rt_lsb     = 16;
    localparam int unsigned rd_lsb     = 11;
    localparam int unsigned shamt_lsb  = 6;

    // memories, both word organised
    localparam int unsigned imem_depth = 64;
    localparam int unsigned dmem_depth = 64;
    localparam int unsigned imem_aw    = $clog2(imem_depth);
    localparam int unsigned dmem_aw    = $clog2(dmem_depth);

    // primary opcode field
    typedef enum logic [opcode_w-1:0] {
        op_r_type = 6'h00,
        op_beq    = 6'h04,
        op_addi   = 6'h08,
        op_lw     = 6'h23,
        op_sw     = 6'h2b
    } opcode_e;

    // funct field of r-type words
    typedef enum logic [funct_w-1:0] {
        fn_sll = 6'h00,
        fn_add = 6'h20,
        fn_sub = 6'h22,
        fn_and = 6'h24,
        fn_or  = 6'h25,
        fn_slt = 6'h2a
    } funct_e;

endpackage

/* logic/pipe_pkg.sv */
package pipe_pkg;

    // operation the execute stage performs
    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_and  = 4'd2,
        alu_or   = 4'd3,
        alu_slt  = 4'd4,
        alu_sll  = 4'd5,
        alu_pass = 4'd6   // second operand straight through
    } alu_op_e;

    // control bundle, produced in decode and carried down the pipe
    typedef struct packed {
        logic    alu_src;    // 1: immediate as second operand
        logic    reg_dst;    // 1: rd is the destination, else rt
        logic    reg_write;
        alu_op_e alu_op;
        logic    mem_write;
        logic    mem_read;
        logic    mem_to_reg; // 1: load data to writeback
        logic    branch;
    } ctrl_t;

    typedef struct packed {
        logic                            valid;
        logic [mips_isa_pkg::xlen-1:0]   pc;
        logic [mips_isa_pkg::xlen-1:0]   instr;
    } if_id_t;

    typedef struct packed {
        logic                                  valid;
        logic [mips_isa_pkg::xlen-1:0]         pc;
        logic [mips_isa_pkg::xlen-1:0]         rs_data;
        logic [mips_isa_pkg::xlen-1:0]         rt_data;
        logic [mips_isa_pkg::xlen-1:0]         imm;     // already sign extended
        logic [mips_isa_pkg::reg_addr_w-1:0]   rt;
        logic [mips_isa_pkg::reg_addr_w-1:0]   rd;
        logic [mips_isa_pkg::shamt_w-1:0]      shamt;
        ctrl_t                                 ctrl;
    } id_ex_t;

    typedef struct packed {
        logic                                  valid;
        logic [mips_isa_pkg::xlen-1:0]         alu_result;
        logic [mips_isa_pkg::xlen-1:0]         store_data;
        logic [mips_isa_pkg::reg_addr_w-1:0]   dest;
        ctrl_t                                 ctrl;
    } ex_mem_t;

    typedef struct packed {
        logic                                  valid;
        logic [mips_isa_pkg::xlen-1:0]         result;
        logic [mips_isa_pkg::reg_addr_w-1:0]   dest;
        logic                                  reg_write; // qualified, never for r0
    } mem_wb_t;

endpackage
